//--- hdl/slurm16_cfg.svh
// slurm16 memory subsystem configuration.
// Word and address widths, RAM depth, wait states and reset vector.

`ifndef SLURM16_CFG_SVH
`define SLURM16_CFG_SVH

// Data and instruction word width.
`define SLURM16_BITS 16

// Memory address width.
`define SLURM16_ADDRESS_BITS 16

// RAM depth in words, addresses wrap modulo this.
`define SLURM16_MEM_WORDS 1024

// Cycles between the start of an access and rdy.
`define SLURM16_WAIT_STATES 2

// First fetch address after reset.
`define SLURM16_RESET_VECTOR 16'h0100

`endif

//--- hdl/slurm16_pkg.sv
// slurm16 shared types for the memory side of the CPU.

`include "slurm16_cfg.svh"

package slurm16_pkg;

	// One data or instruction word.
	typedef logic [`SLURM16_BITS - 1:0] word_t;

	// One memory address.
	typedef logic [`SLURM16_ADDRESS_BITS - 1:0] addr_t;

	// Arbiter states.
	// The two data states are entered only for a load or store;
	// data_rdy is the single cycle in which the data port is released.
	typedef enum logic [1:0] {
		st_idle        = 2'd0, // Nothing granted.
		st_instruction = 2'd1, // Prefetch owns the bus.
		st_data_val    = 2'd2, // Data access waiting for rdy.
		st_data_rdy    = 2'd3  // Data access done, stall low.
	} arb_state_t;

endpackage

//--- hdl/slurm16_mem_if.sv
// slurm16 bus interfaces.
// mem_bus_if runs from the arbiter to the RAM, fetch_bus_if from prefetch to arbiter.

`timescale 1ns/1ps

interface mem_bus_if;

	slurm16_pkg::addr_t address;
	slurm16_pkg::word_t wdata;
	slurm16_pkg::word_t rdata; // Valid while rdy is high.
	logic               wr;
	logic               valid; // Held until rdy.
	logic               rdy;   // One-cycle pulse.

	modport master (
		output address,
		output wdata,
		output wr,
		output valid,
		input  rdata,
		input  rdy
	);

	modport slave (
		input  address,
		input  wdata,
		input  wr,
		input  valid,
		output rdata,
		output rdy
	);

endinterface

interface fetch_bus_if;

	slurm16_pkg::addr_t address;
	slurm16_pkg::word_t data;  // Instruction word, valid with rdy.
	logic               valid; // Held until rdy.
	logic               rdy;

	modport requester (
		output address,
		output valid,
		input  data,
		input  rdy
	);

	modport server (
		input  address,
		input  valid,
		output data,
		output rdy
	);

endinterface

//--- hdl/cpu_memory_interface.sv
// slurm16 memory arbiter.
// Shares one memory bus between the instruction prefetch and the data port.

`timescale 1ns/1ps

module cpu_memory_interface (
	input  logic               CLK,
	input  logic               RSTb,

	// Instruction side.
	fetch_bus_if.server        fetch,

	// Data port.
	input  slurm16_pkg::addr_t data_address,
	input  slurm16_pkg::word_t data_write_value,
	output slurm16_pkg::word_t data_read_value,
	input  logic               data_wr,
	input  logic               data_req,
	output logic               data_stall,

	// Memory side.
	mem_bus_if.master          mem
);

	slurm16_pkg::arb_state_t state;
	slurm16_pkg::arb_state_t state_next;

	slurm16_pkg::word_t data_read_value_r;

	// Port is released only in the completion cycle.
	assign data_stall = (state != slurm16_pkg::st_data_rdy);
	assign data_read_value = data_read_value_r;

	always_ff @(posedge CLK) begin
		if (RSTb == 1'b0) begin
			state <= slurm16_pkg::st_idle;
		end else begin
			state <= state_next;
		end
	end

	// Read word is captured on rdy, so it is stable through data_rdy.
	always_ff @(posedge CLK) begin
		if (state == slurm16_pkg::st_data_val && mem.rdy == 1'b1) begin
			data_read_value_r <= mem.rdata;
		end
	end

	// Next state.
	always_comb begin
		state_next = state;

		case (state)
			slurm16_pkg::st_idle: begin
				if (data_req == 1'b1) begin
					state_next = slurm16_pkg::st_data_val; // Data wins in idle.
				end else if (fetch.valid == 1'b1) begin
					state_next = slurm16_pkg::st_instruction;
				end
			end

			slurm16_pkg::st_instruction: begin
				// Prefetch drops valid for a cycle after each word.
				if (fetch.valid == 1'b0) begin
					state_next = slurm16_pkg::st_idle;
				end
			end

			slurm16_pkg::st_data_val: begin
				if (mem.rdy == 1'b1) begin
					state_next = slurm16_pkg::st_data_rdy;
				end
			end

			slurm16_pkg::st_data_rdy: begin
				state_next = slurm16_pkg::st_idle; // Single release cycle.
			end

			default: begin
				state_next = slurm16_pkg::st_idle;
			end
		endcase
	end

	// Bus outputs.
	// The instruction path is passed straight through while granted.
	always_comb begin
		mem.valid   = 1'b0;
		mem.address = '0;
		mem.wdata   = '0;
		mem.wr      = 1'b0;
		fetch.rdy   = 1'b0;
		fetch.data  = '0;

		case (state)
			slurm16_pkg::st_instruction: begin
				mem.valid   = fetch.valid;
				mem.address = fetch.address;
				fetch.rdy   = mem.rdy;
				fetch.data  = mem.rdata;
			end

			slurm16_pkg::st_data_val: begin
				mem.valid   = 1'b1; // Held until rdy.
				mem.address = data_address;
				mem.wdata   = data_write_value;
				mem.wr      = data_wr;
			end

			default: begin
				mem.valid = 1'b0; // Idle and data_rdy keep the bus quiet.
			end
		endcase
	end

endmodule

//--- hdl/instruction_prefetch.sv
// slurm16 instruction prefetch.
// Program counter, one fetch in flight, two-word buffer and branch handling.

`timescale 1ns/1ps
`include "slurm16_cfg.svh"

module instruction_prefetch (
	input  logic               CLK,
	input  logic               RSTb,
	input  logic               fetch_enable,
	input  logic               branch,
	input  slurm16_pkg::addr_t branch_target,
	output slurm16_pkg::word_t instruction_word,
	output logic               instruction_valid,
	input  logic               instruction_take,
	fetch_bus_if.requester     fetch
);

	slurm16_pkg::addr_t pc;             // Next address to fetch.
	slurm16_pkg::addr_t branch_pc;      // Target held while a fetch finishes.
	logic               pending_branch;
	logic               valid_r;

	slurm16_pkg::word_t buf0;           // Oldest word.
	slurm16_pkg::word_t buf1;
	logic [1:0]         count;

	logic take_fire;
	logic word_fire;

	assign fetch.address = pc;
	assign fetch.valid   = valid_r;

	assign instruction_valid = (count != 2'd0);
	assign instruction_word  = buf0;

	assign take_fire = instruction_take && instruction_valid;
	// Returned word is dropped when a branch has overtaken it.
	assign word_fire = valid_r && fetch.rdy && !pending_branch && !branch;

	always_ff @(posedge CLK) begin
		if (RSTb == 1'b0) begin
			pc             <= `SLURM16_RESET_VECTOR;
			valid_r        <= 1'b0;
			pending_branch <= 1'b0;
		end else if (valid_r == 1'b1) begin
			// Address stays put until the word is back.
			if (fetch.rdy == 1'b1) begin
				valid_r        <= 1'b0; // Gives a waiting data request a slot.
				pending_branch <= 1'b0;
				if (branch == 1'b1)
					pc <= branch_target;
				else if (pending_branch == 1'b1)
					pc <= branch_pc;
				else
					pc <= pc + 1'b1;
			end else if (branch == 1'b1) begin
				pending_branch <= 1'b1;
			end
		end else begin
			if (branch == 1'b1)
				pc <= branch_target;
			// Only request when the word will have a slot.
			if (fetch_enable && (count != 2'd2 || take_fire || branch))
				valid_r <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (branch == 1'b1)
			branch_pc <= branch_target;
	end

	// Buffer occupancy.
	always_ff @(posedge CLK) begin
		if (RSTb == 1'b0) begin
			count <= 2'd0;
		end else if (branch == 1'b1) begin
			count <= 2'd0; // Flush.
		end else if (word_fire && !take_fire) begin
			count <= count + 2'd1;
		end else if (take_fire && !word_fire) begin
			count <= count - 2'd1;
		end
	end

	// Buffer contents, shifted toward buf0 on a pop.
	always_ff @(posedge CLK) begin
		if (take_fire == 1'b1) begin
			buf0 <= buf1;
			if (word_fire == 1'b1) begin
				if (count == 2'd2)
					buf1 <= fetch.data;
				else
					buf0 <= fetch.data;
			end
		end else if (word_fire == 1'b1) begin
			if (count == 2'd0)
				buf0 <= fetch.data;
			else
				buf1 <= fetch.data;
		end
	end

endmodule

//--- hdl/wait_state_sram.sv
// slurm16 single-port RAM model.
// Answers each access with a one-cycle rdy after a fixed number of wait states.

`timescale 1ns/1ps
`include "slurm16_cfg.svh"

module wait_state_sram (
	input  logic      CLK,
	input  logic      RSTb,
	mem_bus_if.slave  mem
);

	localparam int MEM_WORDS = `SLURM16_MEM_WORDS;
	localparam int WAIT      = `SLURM16_WAIT_STATES;
	localparam int IDX_BITS  = $clog2(MEM_WORDS);
	localparam int CNT_BITS  = $clog2(WAIT + 2);

	slurm16_pkg::word_t ram [0:MEM_WORDS - 1];

	logic [IDX_BITS - 1:0] index;
	logic [CNT_BITS - 1:0] wait_cnt;
	logic                  rdy_r;
	logic                  access_done;
	slurm16_pkg::word_t    rdata_r;

	assign index = IDX_BITS'(mem.address % MEM_WORDS); // Wraps at the depth.

	// Silent in the rdy cycle, so a still-high valid does not restart.
	assign access_done = mem.valid && !rdy_r && (wait_cnt == CNT_BITS'(WAIT));

	assign mem.rdy   = rdy_r;
	assign mem.rdata = rdata_r;

	always_ff @(posedge CLK) begin
		if (RSTb == 1'b0) begin
			wait_cnt <= '0;
			rdy_r    <= 1'b0;
		end else begin
			rdy_r <= access_done;
			if (!mem.valid || rdy_r || access_done)
				wait_cnt <= '0; // Abandoned or finished.
			else
				wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (access_done == 1'b1) begin
			if (mem.wr == 1'b1)
				ram[index] <= mem.wdata;
			else
				rdata_r <= ram[index];
		end
	end

endmodule

//--- hdl/slurm16_memory_subsystem.sv
// slurm16 memory subsystem top.
// Prefetch and data port share one wait-state RAM through the arbiter.

`timescale 1ns/1ps

module slurm16_memory_subsystem (
	input  logic               CLK,
	input  logic               RSTb,

	// Instruction output.
	input  logic               fetch_enable,
	input  logic               branch,
	input  slurm16_pkg::addr_t branch_target,
	output slurm16_pkg::word_t instruction_word,
	output logic               instruction_valid,
	input  logic               instruction_take,

	// Data port.
	input  slurm16_pkg::addr_t data_address,
	input  slurm16_pkg::word_t data_write_value,
	output slurm16_pkg::word_t data_read_value,
	input  logic               data_wr,
	input  logic               data_req,
	output logic               data_stall
);

	mem_bus_if   mem_bus ();
	fetch_bus_if fetch_bus ();

	instruction_prefetch prefetch0 (
		.CLK               (CLK),
		.RSTb              (RSTb),
		.fetch_enable      (fetch_enable),
		.branch            (branch),
		.branch_target     (branch_target),
		.instruction_word  (instruction_word),
		.instruction_valid (instruction_valid),
		.instruction_take  (instruction_take),
		.fetch             (fetch_bus.requester)
	);

	// Data requests take priority in idle.
	cpu_memory_interface arbiter0 (
		.CLK               (CLK),
		.RSTb              (RSTb),
		.fetch             (fetch_bus.server),
		.data_address      (data_address),
		.data_write_value  (data_write_value),
		.data_read_value   (data_read_value),
		.data_wr           (data_wr),
		.data_req          (data_req),
		.data_stall        (data_stall),
		.mem               (mem_bus.master)
	);

	wait_state_sram sram0 (
		.CLK               (CLK),
		.RSTb              (RSTb),
		.mem               (mem_bus.slave)
	);

endmodule

//--- tb/slurm16_memory_asserts.sv
// slurm16 arbiter protocol checker.
// Bound into cpu_memory_interface to watch the memory bus and the data port.

`timescale 1ns/1ps

module slurm16_memory_asserts (
	input logic                    CLK,
	input logic                    RSTb,
	input slurm16_pkg::arb_state_t state,
	input logic                    data_req,
	input logic                    data_stall,
	input logic                    mem_valid,
	input slurm16_pkg::addr_t      mem_address,
	input logic                    mem_rdy,
	input logic                    fetch_rdy
);

	int fail_count = 0; // Failed assertions so far.

	hold_until_rdy: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_valid && !mem_rdy |=> mem_valid && $stable(mem_address))
		else begin
			fail_count++;
			$error("Bus valid dropped or address moved before rdy.");
		end

	rdy_single_cycle: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_rdy |-> mem_valid ##1 !mem_rdy)
		else begin
			fail_count++;
			$error("Bus rdy came without valid or lasted longer than one cycle.");
		end

	// Stall falls only right after the RAM answered a data access still requested.
	stall_low_in_data_rdy: assert property (@(posedge CLK) disable iff (!RSTb)
		!data_stall |-> $past(state == slurm16_pkg::st_data_val && data_req && mem_rdy))
		else begin
			fail_count++;
			$error("Data stall low without a completed data access.");
		end

	quiet_after_reset: assert property (@(posedge CLK)
		$rose(RSTb) |-> !mem_valid && !mem_rdy && !fetch_rdy && data_stall)
		else begin
			fail_count++;
			$error("Bus output active right after reset.");
		end

endmodule

bind cpu_memory_interface slurm16_memory_asserts asserts0 (
	.CLK         (CLK),
	.RSTb        (RSTb),
	.state       (state),
	.data_req    (data_req),
	.data_stall  (data_stall),
	.mem_valid   (mem.valid),
	.mem_address (mem.address),
	.mem_rdy     (mem.rdy),
	.fetch_rdy   (fetch.rdy)
);

//--- tb/tb_slurm16_memory.sv
// slurm16 memory subsystem testbench.
// Directed tests of the data port, instruction fetch, back-pressure and branch.

`timescale 1ns/1ps
`include "slurm16_cfg.svh"

module tb_slurm16_memory;

	localparam int MEM_WORDS = `SLURM16_MEM_WORDS;
	localparam int TIMEOUT   = 200; // Cycles allowed for any single wait.

	logic               CLK;
	logic               RSTb;
	logic               fetch_enable;
	logic               branch;
	slurm16_pkg::addr_t branch_target;
	slurm16_pkg::word_t instruction_word;
	logic               instruction_valid;
	logic               instruction_take;
	slurm16_pkg::addr_t data_address;
	slurm16_pkg::word_t data_write_value;
	slurm16_pkg::word_t data_read_value;
	logic               data_wr;
	logic               data_req;
	logic               data_stall;

	slurm16_pkg::word_t ref_mem [0:MEM_WORDS - 1]; // Mirror of every write.
	slurm16_pkg::addr_t exp_pc;                    // Next expected instruction address.
	integer             seed = 32'hec2a;

	slurm16_memory_subsystem dut0 (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Inputs change 1 ns after the edge where outputs have settled.
	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic count_wait(inout int cycles, input string what);
		cycles++;
		if (cycles > TIMEOUT)
			stop_run($sformatf("Timed out waiting for %s.", what));
	endtask

	task automatic check_word(input string name, input slurm16_pkg::word_t got,
			input slurm16_pkg::word_t exp);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input slurm16_pkg::addr_t got,
			input slurm16_pkg::addr_t exp);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	function automatic int mem_index(input slurm16_pkg::addr_t addr);
		return int'(addr) % MEM_WORDS; // RAM wraps at its depth.
	endfunction

	// One data port access that returns the word seen while stall is low.
	task automatic data_access(input logic wr, input slurm16_pkg::addr_t addr,
			input slurm16_pkg::word_t wval, output slurm16_pkg::word_t rval);
		int cycles;
		cycles = 0;
		data_req = 1'b1;
		data_wr = wr;
		data_address = addr;
		data_write_value = wval;
		step();
		while (data_stall !== 1'b0) begin
			count_wait(cycles, "the end of a data access");
			step();
		end
		rval = data_read_value;
		data_req = 1'b0;
		data_wr = 1'b0;
		step();
		check_bit("data_stall", data_stall, 1'b1); // Release window is one cycle.
	endtask

	task automatic data_write(input slurm16_pkg::addr_t addr, input slurm16_pkg::word_t value);
		slurm16_pkg::word_t ignored;
		ref_mem[mem_index(addr)] = value;
		data_access(1'b1, addr, value, ignored);
	endtask

	task automatic data_read(input slurm16_pkg::addr_t addr);
		slurm16_pkg::word_t value;
		data_access(1'b0, addr, '0, value);
		check_word("data_read_value", value, ref_mem[mem_index(addr)]);
	endtask

	// Takes count instruction words and checks them against exp_pc order.
	task automatic run_fetch(input int count);
		int got;
		int cycles;
		got = 0;
		cycles = 0;
		while (got < count) begin
			if (instruction_valid === 1'b1) begin
				check_word("instruction_word", instruction_word, ref_mem[mem_index(exp_pc)]);
				instruction_take = 1'b1;
				exp_pc++;
				got++;
				cycles = 0;
			end else begin
				instruction_take = 1'b0;
				count_wait(cycles, "an instruction word");
			end
			step();
		end
		instruction_take = 1'b0;
	endtask

	task automatic test_reset();
		check_bit("data_stall", data_stall, 1'b1);
		check_bit("instruction_valid", instruction_valid, 1'b0);
		check_addr("fetch_bus.address", dut0.fetch_bus.address, `SLURM16_RESET_VECTOR);
	endtask

	task automatic test_data();
		for (int i = 0; i < 16; i++)
			data_write(slurm16_pkg::addr_t'(16'h0040 + 5 * i),
				slurm16_pkg::word_t'($random(seed)));
		for (int i = 0; i < 16; i++)
			data_read(slurm16_pkg::addr_t'(16'h0040 + 5 * i));
		data_read(16'h0440); // Aliases 0x0040.
	endtask

	task automatic test_sequential_fetch();
		for (int i = 0; i < 64; i++)
			data_write(slurm16_pkg::addr_t'(`SLURM16_RESET_VECTOR + i),
				slurm16_pkg::word_t'($random(seed)));
		exp_pc = `SLURM16_RESET_VECTOR;
		fetch_enable = 1'b1;
		run_fetch(8);
	endtask

	task automatic test_back_pressure();
		slurm16_pkg::word_t held;
		int cycles;
		cycles = 0;
		while (instruction_valid !== 1'b1) begin
			count_wait(cycles, "a buffered instruction word");
			step();
		end
		held = instruction_word;
		check_word("instruction_word", held, ref_mem[mem_index(exp_pc)]);
		repeat (12) begin
			step();
			check_bit("instruction_valid", instruction_valid, 1'b1);
			check_word("instruction_word", instruction_word, held);
		end
		run_fetch(6);
	endtask

	task automatic test_branch();
		int cycles;
		cycles = 0;
		// Keep consuming until a fetch is waiting on the RAM.
		while (!(dut0.fetch_bus.valid === 1'b1 && dut0.fetch_bus.rdy === 1'b0)) begin
			if (instruction_valid === 1'b1) begin
				check_word("instruction_word", instruction_word, ref_mem[mem_index(exp_pc)]);
				exp_pc++;
			end
			instruction_take = instruction_valid;
			count_wait(cycles, "a fetch in flight");
			step();
		end
		instruction_take = 1'b0;
		branch = 1'b1;
		branch_target = 16'h0130;
		step();
		branch = 1'b0;
		check_bit("instruction_valid", instruction_valid, 1'b0); // Buffer flushed.
		exp_pc = 16'h0130;
		run_fetch(4);
	endtask

	task automatic test_data_during_fetch();
		fork
			run_fetch(12);
			begin
				for (int i = 0; i < 4; i++)
					data_write(slurm16_pkg::addr_t'(16'h0300 + i),
						slurm16_pkg::word_t'($random(seed)));
				for (int i = 0; i < 4; i++)
					data_read(slurm16_pkg::addr_t'(16'h0300 + i));
			end
		join
		fetch_enable = 1'b0;
	endtask

	initial begin
		RSTb = 1'b0;
		fetch_enable = 1'b0;
		branch = 1'b0;
		branch_target = '0;
		instruction_take = 1'b0;
		data_address = '0;
		data_write_value = '0;
		data_wr = 1'b0;
		data_req = 1'b0;
		repeat (16) @(posedge CLK);
		#1;
		RSTb = 1'b1;
		test_reset();
		test_data();
		test_sequential_fetch();
		test_back_pressure();
		test_branch();
		test_data_during_fetch();
		step();
		if (dut0.arbiter0.asserts0.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- slurm16_memory_subsystem.f
+incdir+hdl
hdl/slurm16_pkg.sv
hdl/slurm16_mem_if.sv
hdl/cpu_memory_interface.sv
hdl/instruction_prefetch.sv
hdl/wait_state_sram.sv
hdl/slurm16_memory_subsystem.sv
tb/slurm16_memory_asserts.sv
tb/tb_slurm16_memory.sv

//--- Makefile
VERILATOR = verilator
TOP       = tb_slurm16_memory
FILELIST  = slurm16_memory_subsystem.f
FLAGS     = --timing --assert --timescale 1ns/1ps -Wno-fatal
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "STATUS: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)."; exit 1)
	@echo "Simulation passed."

clean:
	rm -rf $(BUILD_DIR) $(LOG)
